//--- hw/branch_target.sv
module branch_target (
	input  rv_isa_pkg::decoded_t dec,
	input  rv_isa_pkg::word_t    pc,
	input  rv_isa_pkg::word_t    rs1_val,
	input  rv_isa_pkg::word_t    rs2_val,
	output rv_isa_pkg::word_t    target,
	output logic                 redirect
);

	import rv_isa_pkg::*;

	logic  eq;
	logic  lt_s;
	logic  lt_u;
	logic  cond;
	logic  taken;
	word_t base;
	word_t imm;
	word_t sum;

	assign eq   = (rs1_val == rs2_val);
	assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
	assign lt_u = (rs1_val < rs2_val);

	always_comb begin
		case (dec.funct3)
			f3_beq:  cond = eq;
			f3_bne:  cond = !eq;
			f3_blt:  cond = lt_s;
			f3_bge:  cond = !lt_s;
			f3_bltu: cond = lt_u;
			f3_bgeu: cond = !lt_u;
			default: cond = 1'b0;   // reserved funct3, fall through
		endcase
	end

	assign taken = dec.is_branch && cond;

	// jalr adds to rs1, everything else is pc relative
	assign base = dec.is_jalr ? rs1_val : pc;

	always_comb begin
		if (dec.is_jalr)
			imm = dec.imm_i;
		else if (dec.is_jal)
			imm = dec.imm_j;
		else
			imm = dec.imm_b;
	end

	assign sum = base + imm;

	// jalr drops the low bit of the sum
	assign target = dec.is_jalr ? {sum[xlen-1:1], 1'b0} : sum;

	assign redirect = taken || dec.is_jal || dec.is_jalr;

	// pc relative targets rely on an even pc from pc_reg
	always_comb begin
		assert final (!redirect || !target[0])
			else $error("redirect target 0x%08h is odd", target);
	end

endmodule

//--- hw/fetch_core.sv
module fetch_core (
	input  logic               clk,
	input  logic               rst,
	input  rv_isa_pkg::word_t  instr,
	input  logic               instr_valid,
	input  fetch_pkg::wb_t     wb,
	output rv_isa_pkg::word_t  pc,
	output fetch_pkg::retire_t retire
);

	import rv_isa_pkg::*;

	decoded_t dec;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    target;
	logic     redirect;
	logic     link_en;
	word_t    link_data;

	instr_decode u_decode (
		.instr (instr),
		.dec   (dec)
	);

	reg_file u_regs (
		.clk       (clk),
		.rst       (rst),
		.rs1_addr  (dec.rs1),
		.rs2_addr  (dec.rs2),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.link_en   (link_en),
		.link_addr (dec.rd),   // link goes to rd of the jump
		.link_data (link_data),
		.wb        (wb)
	);

	branch_target u_target (
		.dec      (dec),
		.pc       (pc),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.target   (target),
		.redirect (redirect)
	);

	pc_reg u_pc (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.dec         (dec),
		.redirect    (redirect),
		.target      (target),
		.pc          (pc),
		.link_en     (link_en),
		.link_data   (link_data),
		.retire      (retire)
	);

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

	import rv_isa_pkg::*;

	localparam word_t reset_vector = 32'h0000_0000;
	localparam int    reg_count    = 32;

	// external register write, used to preload operands
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	// one record per accepted instruction
	typedef struct packed {
		logic  valid;
		logic  redirect;   // target taken instead of pc + 4
		word_t pc;
		word_t next_pc;
	} retire_t;

endpackage

//--- hw/instr_decode.sv
module instr_decode (
	input  rv_isa_pkg::word_t    instr,
	output rv_isa_pkg::decoded_t dec
);

	import rv_isa_pkg::*;

	opcode_t opcode;
	word_t   imm_b;
	word_t   imm_j;
	word_t   imm_i;

	assign opcode = instr[6:0];

	// b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	// j-type: imm[20|10:1|11|19:12]
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// i-type, no implied zero bit
	assign imm_i = {{20{instr[31]}}, instr[31:20]};

	always_comb begin
		dec.opcode    = opcode;
		dec.funct3    = instr[14:12];
		dec.rs1       = instr[19:15];
		dec.rs2       = instr[24:20];
		dec.rd        = instr[11:7];
		dec.imm_b     = imm_b;
		dec.imm_j     = imm_j;
		dec.imm_i     = imm_i;
		dec.is_branch = (opcode == op_branch);
		dec.is_jal    = (opcode == op_jal);
		dec.is_jalr   = (opcode == op_jalr);
	end

endmodule

//--- hw/pc_reg.sv
module pc_reg (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instr_valid,
	input  rv_isa_pkg::decoded_t dec,
	input  logic                 redirect,
	input  rv_isa_pkg::word_t    target,
	output rv_isa_pkg::word_t    pc,
	output logic                 link_en,
	output rv_isa_pkg::word_t    link_data,
	output fetch_pkg::retire_t   retire
);

	import rv_isa_pkg::*;
	import fetch_pkg::*;

	word_t pc_plus4;   // shared by fall-through and link
	word_t next_pc;

	logic  ret_valid;
	logic  ret_redirect;
	word_t ret_pc;
	word_t ret_next_pc;

	assign pc_plus4 = pc + 32'd4;
	assign next_pc  = redirect ? target : pc_plus4;

	// rd address comes straight from dec.rd at the top
	assign link_en   = instr_valid && (dec.is_jal || dec.is_jalr) && (dec.rd != '0);
	assign link_data = pc_plus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= reset_vector;
			ret_valid <= 1'b0;
		end else begin
			ret_valid <= instr_valid;
			if (instr_valid)
				pc <= next_pc;   // hold otherwise
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ret_redirect <= redirect;
			ret_pc       <= pc;
			ret_next_pc  <= next_pc;
		end
	end

	assign retire = '{valid: ret_valid, redirect: ret_redirect,
	                  pc: ret_pc, next_pc: ret_next_pc};

	// holds across branch_target, which only clears bit 0 for jalr
	a_pc_even: assert property (@(posedge clk) disable iff (rst) !pc[0])
		else $error("pc 0x%08h has bit 0 set", pc);

endmodule

//--- hw/reg_file.sv
module reg_file (
	input  logic                 clk,
	input  logic                 rst,
	input  rv_isa_pkg::reg_addr_t rs1_addr,
	input  rv_isa_pkg::reg_addr_t rs2_addr,
	output rv_isa_pkg::word_t    rs1_val,
	output rv_isa_pkg::word_t    rs2_val,
	input  logic                 link_en,
	input  rv_isa_pkg::reg_addr_t link_addr,
	input  rv_isa_pkg::word_t    link_data,
	input  fetch_pkg::wb_t       wb
);

	import rv_isa_pkg::*;
	import fetch_pkg::*;

	word_t regs [0:reg_count-1];   // x0 stays zero through the write guard

	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	// link write takes the port and drops the external write
	assign wr_en   = link_en || wb.en;
	assign wr_addr = link_en ? link_addr : wb.addr;
	assign wr_data = link_en ? link_data : wb.data;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_val = regs[rs1_addr];
	assign rs2_val = regs[rs2_addr];

	// writes aimed at x0 must leave no trace
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		(wr_en && wr_addr == '0) |=> (regs[0] == '0))
		else $error("x0 changed after a write");

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;    // data, address, instruction word
	typedef logic [4:0]      reg_addr_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;

	// control transfer opcodes
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_jal    = 7'b1101111;
	localparam opcode_t op_jalr   = 7'b1100111;

	// branch conditions
	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	// fields the fetch side needs, immediates already extended
	typedef struct packed {
		opcode_t   opcode;
		funct3_t   funct3;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm_b;     // 2-byte units
		word_t     imm_j;     // 2-byte units
		word_t     imm_i;     // byte granular, jalr
		logic      is_branch;
		logic      is_jal;
		logic      is_jalr;
	} decoded_t;

endpackage

//--- sim/fetch_core_tb.sv
module fetch_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rv_isa_pkg::*;
	import fetch_pkg::*;

	localparam int reset_cycles = 8;
	localparam word_t nop = 32'h0000_0013;   // addi x0, x0, 0

	// how a row fills its wb data
	localparam logic [2:0] wb_fixed = 3'd0;
	localparam logic [2:0] wb_rand  = 3'd1;
	localparam logic [2:0] wb_neg   = 3'd2;
	localparam logic [2:0] wb_pos   = 3'd3;
	localparam logic [2:0] wb_same  = 3'd4;   // repeat last random value
	localparam logic [2:0] wb_inv   = 3'd5;   // bitwise inverse of last random

	typedef struct packed {
		logic       valid;
		word_t      instr;
		logic       wb_en;
		reg_addr_t  wb_addr;
		logic [2:0] wb_mode;
		word_t      wb_data;
		logic       exp_redirect;
		word_t      exp_next_pc;
	} row_t;

	logic    clk;
	logic    rst;
	word_t   instr;
	logic    instr_valid;
	wb_t     wb;
	word_t   pc;
	retire_t retire;

	row_t        rows[$];
	word_t       m_regs [0:31];   // reference register file
	word_t       m_pc;
	word_t       last_rand;
	logic [15:0] lfsr = 16'd80;
	int          errors = 0;
	int          cycles = 0;

	fetch_core UUT (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb          (wb),
		.pc          (pc),
		.retire      (retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hang guard sized from the table
	always @(posedge clk) begin
		cycles++;
		if (cycles > rows.size() * 4 + reset_cycles) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_word(output word_t w);
		w = '0;
		for (int i = 0; i < xlen; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[xlen-2:0], lfsr[0]};
		end
	endtask

	task automatic make_wb_data(input logic [2:0] mode, input word_t fixed, output word_t d);
		case (mode)
			wb_rand: rand_word(last_rand);
			wb_neg: begin
				rand_word(last_rand);
				last_rand[31] = 1'b1;
			end
			wb_pos: begin
				rand_word(last_rand);
				last_rand[31] = 1'b0;
			end
			default: ;
		endcase
		if (mode == wb_fixed)
			d = fixed;
		else if (mode == wb_inv)
			d = ~last_rand;
		else
			d = last_rand;
	endtask

	function automatic word_t enc_branch(input funct3_t f3, input reg_addr_t rs1,
	                                     input reg_addr_t rs2, input int off);
		logic [12:0] i;
		i = off[12:0];
		return {i[12], i[10:5], rs2, rs1, f3, i[4:1], i[11], op_branch};
	endfunction

	function automatic word_t enc_jal(input reg_addr_t rd, input int off);
		logic [20:0] i;
		i = off[20:0];
		return {i[20], i[10:1], i[11], i[19:12], rd, op_jal};
	endfunction

	function automatic word_t enc_jalr(input reg_addr_t rd, input reg_addr_t rs1, input int off);
		return {off[11:0], rs1, 3'b000, rd, op_jalr};
	endfunction

	task automatic add_row(input logic valid, input word_t ins, input logic wb_en,
	                       input reg_addr_t wb_addr, input logic [2:0] wb_mode,
	                       input word_t wb_data, input logic redir, input word_t next_pc);
		rows.push_back('{valid, ins, wb_en, wb_addr, wb_mode, wb_data, redir, next_pc});
	endtask

	// expected redirect and next pc from the ISA rules
	task automatic predict(input word_t ins, input word_t pc_in,
	                       output logic redir, output word_t nxt);
		word_t a;
		word_t b;
		int    imm_b;
		int    imm_j;
		int    imm_i;
		logic  t;
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		imm_b = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
		imm_j = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
		imm_i = $signed(ins[31:20]);
		redir = 1'b1;
		if (ins[6:0] == op_branch) begin
			case (ins[14:12])
				f3_beq:  t = (a == b);
				f3_bne:  t = (a != b);
				f3_blt:  t = ($signed(a) < $signed(b));
				f3_bge:  t = ($signed(a) >= $signed(b));
				f3_bltu: t = (a < b);
				f3_bgeu: t = (a >= b);
				default: t = 1'b0;
			endcase
			redir = t;
			nxt = t ? pc_in + imm_b : pc_in + 4;
		end else if (ins[6:0] == op_jal) begin
			nxt = pc_in + imm_j;
		end else if (ins[6:0] == op_jalr) begin
			nxt = (a + imm_i) & ~32'h1;
		end else begin
			redir = 1'b0;
			nxt = pc_in + 4;
		end
	endtask

	task automatic check_value(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
			         $time, what, actual, expected);
			errors++;
		end
	endtask

	initial begin
		row_t  row;
		word_t d;
		word_t pc_before;
		word_t m_next;
		logic  m_redir;
		int    errs_before;
		int    passed;
		int    failed;

		rst = 1'b1;
		instr = nop;
		instr_valid = 1'b0;
		wb = '0;
		passed = 0;
		failed = 0;

		add_row(0, nop, 0, 5'd0, wb_fixed, '0, 0, 32'd0);   // hold right after reset
		add_row(1, nop, 1, 5'd1, wb_rand, '0, 0, 32'd4);
		add_row(1, nop, 1, 5'd2, wb_same, '0, 0, 32'd8);
		add_row(1, nop, 1, 5'd3, wb_inv, '0, 0, 32'd12);
		add_row(1, enc_branch(f3_beq, 5'd1, 5'd2, 16), 0, 5'd0, wb_fixed, '0, 1, 32'd28);
		add_row(1, enc_branch(f3_beq, 5'd1, 5'd3, 16), 0, 5'd0, wb_fixed, '0, 0, 32'd32);
		add_row(1, enc_branch(f3_bne, 5'd1, 5'd3, -24), 0, 5'd0, wb_fixed, '0, 1, 32'd8);
		add_row(1, enc_branch(f3_bne, 5'd1, 5'd2, -8), 0, 5'd0, wb_fixed, '0, 0, 32'd12);
		add_row(1, nop, 1, 5'd4, wb_neg, '0, 0, 32'd16);
		add_row(1, nop, 1, 5'd5, wb_pos, '0, 0, 32'd20);
		add_row(1, enc_branch(f3_blt, 5'd4, 5'd5, 8), 0, 5'd0, wb_fixed, '0, 1, 32'd28);
		add_row(1, enc_branch(f3_bltu, 5'd4, 5'd5, 8), 0, 5'd0, wb_fixed, '0, 0, 32'd32);
		add_row(1, enc_branch(f3_bge, 5'd4, 5'd5, 8), 0, 5'd0, wb_fixed, '0, 0, 32'd36);
		add_row(1, enc_branch(f3_bgeu, 5'd4, 5'd5, 12), 0, 5'd0, wb_fixed, '0, 1, 32'd48);
		add_row(0, nop, 0, 5'd0, wb_fixed, '0, 0, 32'd48);
		add_row(1, enc_jal(5'd6, 256), 0, 5'd0, wb_fixed, '0, 1, 32'd304);
		add_row(1, enc_jalr(5'd7, 5'd6, 5), 0, 5'd0, wb_fixed, '0, 1, 32'd56);
		// wb to the same rd as the jump loses to the link value
		add_row(1, enc_jal(5'd8, -40), 1, 5'd8, wb_fixed, 32'hdead_beef, 1, 32'd16);
		add_row(1, nop, 1, 5'd0, wb_fixed, 32'h1234_5678, 0, 32'd20);
		add_row(1, enc_jalr(5'd0, 5'd8, 3), 0, 5'd0, wb_fixed, '0, 1, 32'd62);
		add_row(1, enc_jalr(5'd9, 5'd0, 'h101), 0, 5'd0, wb_fixed, '0, 1, 32'd256);
		add_row(1, enc_jalr(5'd0, 5'd9, -6), 0, 5'd0, wb_fixed, '0, 1, 32'd60);
		add_row(1, nop, 0, 5'd0, wb_fixed, '0, 0, 32'd64);

		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		m_pc = reset_vector;

		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		check_value(pc, reset_vector, "pc after reset");
		check_value(retire.valid, 1'b0, "retire.valid after reset");
		if (errors == 0) begin
			passed++;
			$display("reset: ok");
		end else begin
			failed++;
			$display("reset: %0d mismatches", errors);
		end

		for (int r = 0; r < rows.size(); r++) begin
			row = rows[r];
			errs_before = errors;
			make_wb_data(row.wb_mode, row.wb_data, d);
			predict(row.instr, m_pc, m_redir, m_next);
			pc_before = m_pc;
			instr = row.instr;
			instr_valid = row.valid;
			wb = '{en: row.wb_en, addr: row.wb_addr, data: d};
			@(posedge clk);
			#1;
			if (row.valid) begin
				check_value(retire.valid, 1'b1, "retire.valid");
				check_value(retire.pc, pc_before, "retire.pc");
				check_value(retire.redirect, row.exp_redirect, "retire.redirect");
				check_value(retire.redirect, m_redir, "retire.redirect vs model");
				check_value(retire.next_pc, row.exp_next_pc, "retire.next_pc");
				check_value(pc, m_next, "pc vs model");
			end else begin
				check_value(retire.valid, 1'b0, "retire.valid on hold");
				check_value(pc, pc_before, "pc on hold");
			end
			// link write takes the port over wb
			if (row.valid && (row.instr[6:0] == op_jal || row.instr[6:0] == op_jalr) &&
			    row.instr[11:7] != 5'd0)
				m_regs[row.instr[11:7]] = m_pc + 4;
			else if (row.wb_en && row.wb_addr != 5'd0)
				m_regs[row.wb_addr] = d;
			if (row.valid)
				m_pc = m_next;
			if (errors == errs_before) begin
				passed++;
				$display("row %0d at pc 0x%08h: ok", r, pc_before);
			end else begin
				failed++;
				$display("row %0d at pc 0x%08h: %0d mismatches",
				         r, pc_before, errors - errs_before);
			end
		end

		instr_valid = 1'b0;
		wb = '0;
		$display("summary: %0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- tb.f
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/instr_decode.sv
hw/branch_target.sv
hw/reg_file.sv
hw/pc_reg.sv
hw/fetch_core.sv
sim/fetch_core_tb.sv
